/* src/mac_rx_pkg.sv */
`default_nettype none

package mac_rx_pkg;

  // ==========================================================
  // line speed
  // ==========================================================

  // 10M and 100M deliver nibbles, 1000M delivers bytes
  typedef enum logic [1:0] {
    spd_10   = 2'd0,
    spd_100  = 2'd1,
    spd_1000 = 2'd2
  } speed_t;

  // ==========================================================
  // frame parser state
  // ==========================================================

  typedef enum logic [1:0] {
    st_idle     = 2'd0,  // waiting for rx_dv to rise
    st_preamble = 2'd1,  // frame admitted, hunting for sfd
    st_data     = 2'd2,  // storing bytes
    st_commit   = 2'd3   // descriptor write
  } parse_state_t;

  // ==========================================================
  // frame descriptor
  // ==========================================================

  localparam int len_w = 12;  // byte count width, holds up to 4095

  typedef struct packed {
    logic             crc_err;   // residue mismatch
    logic             len_err;   // runt or truncated frame
    logic [len_w-1:0] byte_len;  // bytes stored, fcs included
  } rx_desc_t;

  // ==========================================================
  // protocol constants
  // ==========================================================

  // start-frame delimiter, low nibble 5 goes first on mii
  localparam logic [7:0] sfd_byte = 8'hd5;

  // register value after a good frame plus its fcs, normal bit order
  localparam logic [31:0] crc_residue = 32'hc704dd7b;

  // shortest legal frame, fcs included
  localparam int min_frame = 64;

endpackage

`default_nettype wire

/* src/mac_rx_crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_rx_crc32 (
  input  wire       rx_clk,
  input  wire       rstn,
  input  wire       init,     // preset to all ones
  input  wire       byte_en,  // fold byte_in into the register
  input  wire [7:0] byte_in,
  output logic      crc_ok    // register holds the good-frame residue
);

  // 04c11db7 bit reversed, register shifts right lsb first
  localparam logic [31:0] poly_refl = 32'hedb88320;

  logic [31:0] crc_q;
  logic [31:0] crc_next;
  logic [31:0] crc_norm;

  // ==========================================================
  // one byte per step, bit 0 of the byte enters first
  // ==========================================================
  always_comb begin : crc_step
    crc_next = crc_q;
    for (int i = 0; i < 8; i++) begin
      if (crc_next[0] ^ byte_in[i]) begin
        crc_next = (crc_next >> 1) ^ poly_refl;
      end else begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      crc_q <= '1;
    end else if (init) begin
      crc_q <= '1;  // frame start wins over data
    end else if (byte_en) begin
      crc_q <= crc_next;
    end
  end

  // reflected register reads as debb20e3 after a good frame,
  // flip it back to normal order before the compare
  always_comb begin : bit_flip
    for (int i = 0; i < 32; i++) begin
      crc_norm[i] = crc_q[31-i];
    end
  end

  assign crc_ok = (crc_norm == mac_rx_pkg::crc_residue);

endmodule

`default_nettype wire

/* src/mac_rx_sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_rx_sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  wire                             rx_clk,
  input  wire                             rstn,
  input  wire                             wr_en,
  input  wire  [WIDTH-1:0]                wr_data,
  input  wire                             rd_ready,
  output logic                            rd_valid,
  output logic [WIDTH-1:0]                rd_data,
  output logic [$clog2(DEPTH+1)-1:0]      level,
  output logic                            full
);

  localparam int aw = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
  localparam int lw = $clog2(DEPTH + 1);                // occupancy width

  logic [WIDTH-1:0] mem [DEPTH];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic [lw-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  // pointer advance, wraps for any depth
  function automatic logic [aw-1:0] ptr_inc(input logic [aw-1:0] ptr);
    return (ptr == aw'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_wr    = wr_en && !full;       // writer is expected to respect full
  assign do_rd    = rd_ready && rd_valid;
  assign rd_valid = (count != '0);        // fall-through, head word already on rd_data
  assign full     = (count == lw'(DEPTH));
  assign level    = count;
  assign rd_data  = mem[rd_ptr];

  // ==========================================================
  // storage
  // ==========================================================
  always_ff @(posedge rx_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ==========================================================
  // pointers and occupancy
  // ==========================================================
  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // upstream admission must keep writes away from a full fifo
  a_no_overflow: assert property (@(posedge rx_clk) disable iff (!rstn)
    wr_en |-> !full);

endmodule

`default_nettype wire

/* src/mac_rx_frame_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_rx_frame_parser #(
  parameter int MAX_FRAME  = 1518,
  parameter int DATA_DEPTH = 4096,
  parameter int DESC_DEPTH = 8
) (
  input  wire                              rx_clk,
  input  wire                              rstn,
  input  wire                              rx_dv,
  input  wire  [7:0]                       rx_d,        // low nibble only at 10M/100M
  input  wire  mac_rx_pkg::speed_t         speed,       // static over a frame
  input  wire  [$clog2(DATA_DEPTH+1)-1:0]  data_level,  // data fifo fill
  input  wire                              desc_full,
  output logic                             wr_en,       // data fifo and crc byte strobe
  output logic [7:0]                       wr_byte,
  output logic                             crc_init,
  input  wire                              crc_ok,
  output logic                             desc_wr,
  output mac_rx_pkg::rx_desc_t             desc_in
);

  localparam int len_w = mac_rx_pkg::len_w;
  localparam logic [len_w-1:0] max_len = len_w'(MAX_FRAME);
  localparam logic [len_w-1:0] min_len = len_w'(mac_rx_pkg::min_frame);
  localparam int admit_max = DATA_DEPTH - MAX_FRAME;  // highest fill that still fits a frame

  logic [7:0]               d_s0;       // newest sample
  logic [7:0]               d_s1;       // previous sample, low nibble partner
  logic                     dv_s0;
  logic                     dv_s1;
  mac_rx_pkg::parse_state_t state;
  logic                     nib_hi;     // d_s0 holds a high nibble
  logic [len_w-1:0]         byte_cnt;   // bytes stored this frame
  logic                     trunc;      // bytes seen past MAX_FRAME
  logic                     byte_mode;
  logic                     dv_sof;
  logic                     sfd_hit;
  logic                     room;
  logic                     byte_rdy;
  logic                     go_data;

  // ==========================================================
  // input pipeline
  // ==========================================================
  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      dv_s0 <= 1'b0;
      dv_s1 <= 1'b0;
    end else begin
      dv_s0 <= rx_dv;
      dv_s1 <= dv_s0;
    end
  end

  always_ff @(posedge rx_clk) begin
    d_s0 <= rx_d;
    d_s1 <= d_s0;
  end

  // ==========================================================
  // frame events
  // ==========================================================
  assign byte_mode = (speed == mac_rx_pkg::spd_1000);
  assign dv_sof    = dv_s0 && !dv_s1;

  // nibble mode sees the sfd as a 5 followed by a d
  always_comb begin
    if (byte_mode) begin
      sfd_hit = dv_s0 && (d_s0 == mac_rx_pkg::sfd_byte);
    end else begin
      sfd_hit = dv_s0 && dv_s1
             && (d_s0[3:0] == mac_rx_pkg::sfd_byte[7:4])
             && (d_s1[3:0] == mac_rx_pkg::sfd_byte[3:0]);
    end
  end

  // admission, a whole max frame must fit plus one descriptor slot
  assign room     = (int'(data_level) <= admit_max) && !desc_full;
  assign byte_rdy = dv_s0 && (byte_mode || nib_hi);
  assign go_data  = ((state == mac_rx_pkg::st_idle) && dv_sof && room && sfd_hit)
                 || ((state == mac_rx_pkg::st_preamble) && sfd_hit);

  // ==========================================================
  // frame state machine
  // ==========================================================
  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      state <= mac_rx_pkg::st_idle;
    end else begin
      case (state)
        mac_rx_pkg::st_idle: begin
          if (dv_sof && room) begin  // no room means the frame is skipped
            state <= sfd_hit ? mac_rx_pkg::st_data : mac_rx_pkg::st_preamble;
          end
        end
        mac_rx_pkg::st_preamble: begin
          if (!dv_s0) begin
            state <= mac_rx_pkg::st_idle;  // no sfd, drop silently
          end else if (sfd_hit) begin
            state <= mac_rx_pkg::st_data;
          end
        end
        mac_rx_pkg::st_data: begin
          if (!dv_s0) state <= mac_rx_pkg::st_commit;  // last byte still in flight
        end
        mac_rx_pkg::st_commit: begin
          state <= mac_rx_pkg::st_idle;
        end
        default: state <= mac_rx_pkg::st_idle;
      endcase
    end
  end

  // ==========================================================
  // byte assembly and store
  // ==========================================================
  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      wr_en    <= 1'b0;
      crc_init <= 1'b0;
      nib_hi   <= 1'b0;
      byte_cnt <= '0;
      trunc    <= 1'b0;
    end else begin
      wr_en    <= 1'b0;
      crc_init <= go_data;  // one pulse ahead of the first byte
      if (go_data) begin
        nib_hi   <= 1'b0;  // first data nibble is a low one
        byte_cnt <= '0;
        trunc    <= 1'b0;
      end else if ((state == mac_rx_pkg::st_data) && dv_s0) begin
        nib_hi <= !nib_hi;
        if (byte_rdy) begin
          if (byte_cnt == max_len) begin
            trunc <= 1'b1;  // overflow, not stored
          end else begin
            wr_en    <= 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge rx_clk) begin
    wr_byte <= byte_mode ? d_s0 : {d_s0[3:0], d_s1[3:0]};
  end

  // ==========================================================
  // descriptor, crc has seen the last byte by st_commit
  // ==========================================================
  assign desc_wr = (state == mac_rx_pkg::st_commit);

  always_comb begin
    desc_in.byte_len = byte_cnt;
    desc_in.crc_err  = !crc_ok;
    desc_in.len_err  = trunc || (byte_cnt < min_len);
  end

  // speed may only change between frames
  a_speed_stable: assert property (@(posedge rx_clk) disable iff (!rstn)
    (state != mac_rx_pkg::st_idle) |-> $stable(speed));

  // admission check at frame start must keep the descriptor fifo from overflowing
  a_desc_room: assert property (@(posedge rx_clk) disable iff (!rstn)
    desc_wr |-> !desc_full);

  initial begin
    assert (MAX_FRAME <= DATA_DEPTH && MAX_FRAME < (1 << len_w) && DESC_DEPTH >= 1)
      else $error("mac_rx_frame_parser: bad fifo or frame size configuration");
  end

endmodule

`default_nettype wire

/* src/mac_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_rx_top #(
  parameter int MAX_FRAME  = 1518,
  parameter int DATA_DEPTH = 4096,
  parameter int DESC_DEPTH = 8
) (
  input  wire                       rx_clk,
  input  wire                       rstn,
  input  wire                       rx_dv,
  input  wire  [7:0]                rx_d,
  input  wire  mac_rx_pkg::speed_t  speed,
  input  wire                       data_ready,
  input  wire                       desc_ready,
  output logic                      data_valid,
  output logic [7:0]                data_byte,
  output logic                      desc_valid,
  output mac_rx_pkg::rx_desc_t      desc
);

  localparam int desc_w = $bits(mac_rx_pkg::rx_desc_t);
  localparam int lvl_w  = $clog2(DATA_DEPTH + 1);

  logic                 wr_en;       // parser byte strobe
  logic [7:0]           wr_byte;
  logic                 crc_init;
  logic                 crc_ok;
  logic                 desc_wr;
  mac_rx_pkg::rx_desc_t desc_in;
  logic [lvl_w-1:0]     data_level;  // for admission
  logic                 desc_full;

  // ==========================================================
  // parser and crc checker share one byte stream
  // ==========================================================
  mac_rx_frame_parser #(
    .MAX_FRAME  (MAX_FRAME),
    .DATA_DEPTH (DATA_DEPTH),
    .DESC_DEPTH (DESC_DEPTH)
  ) i_parser (
    .rx_clk     (rx_clk),
    .rstn       (rstn),
    .rx_dv      (rx_dv),
    .rx_d       (rx_d),
    .speed      (speed),
    .data_level (data_level),
    .desc_full  (desc_full),
    .wr_en      (wr_en),
    .wr_byte    (wr_byte),
    .crc_init   (crc_init),
    .crc_ok     (crc_ok),
    .desc_wr    (desc_wr),
    .desc_in    (desc_in)
  );

  mac_rx_crc32 i_crc (
    .rx_clk  (rx_clk),
    .rstn    (rstn),
    .init    (crc_init),
    .byte_en (wr_en),
    .byte_in (wr_byte),
    .crc_ok  (crc_ok)
  );

  // ==========================================================
  // output fifos
  // ==========================================================
  mac_rx_sync_fifo #(.WIDTH(8), .DEPTH(DATA_DEPTH)) i_data_fifo (
    .rx_clk (rx_clk),
    .rstn   (rstn),
    .wr_en  (wr_en),
    .wr_data(wr_byte),
    .rd_ready(data_ready),
    .rd_valid(data_valid),
    .rd_data(data_byte),
    .level  (data_level),
    .full   ()             // admission keeps a max frame of headroom
  );

  mac_rx_sync_fifo #(.WIDTH(desc_w), .DEPTH(DESC_DEPTH)) i_desc_fifo (
    .rx_clk (rx_clk),
    .rstn   (rstn),
    .wr_en  (desc_wr),
    .wr_data(desc_in),
    .rd_ready(desc_ready),
    .rd_valid(desc_valid),
    .rd_data(desc),
    .level  (),
    .full   (desc_full)
  );

endmodule

`default_nettype wire

/* testbench/tb_mac_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mac_rx;

  localparam int max_frame  = 1518;
  localparam int desc_depth = 4;
  localparam int wait_limit = 4000;  // cycles allowed per wait loop

  logic                 rx_clk;
  logic                 rstn;
  logic                 rx_dv;
  logic [7:0]           rx_d;
  mac_rx_pkg::speed_t   speed;
  logic                 data_ready;
  logic                 desc_ready;
  logic                 data_valid;
  logic [7:0]           data_byte;
  logic                 desc_valid;
  mac_rx_pkg::rx_desc_t desc;

  logic [31:0] lcg_state;
  logic [7:0]  frame_q[$];   // frame on the wire after the sfd, fcs included
  logic [7:0]  pend_q[$];    // accepted frames back to back
  int          pend_len[$];  // size of each accepted frame

  mac_rx_top #(.MAX_FRAME(max_frame), .DESC_DEPTH(desc_depth)) i_dut (
    .rx_clk     (rx_clk),
    .rstn       (rstn),
    .rx_dv      (rx_dv),
    .rx_d       (rx_d),
    .speed      (speed),
    .data_ready (data_ready),
    .desc_ready (desc_ready),
    .data_valid (data_valid),
    .data_byte  (data_byte),
    .desc_valid (desc_valid),
    .desc       (desc)
  );

  initial begin
    rx_clk = 1'b0;
    forever #2 rx_clk = ~rx_clk;  // 4 ns period
  end

  // ============================================================
  // reference models
  // ============================================================
  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];  // upper bits, better spread
  endfunction

  // ieee 802.3 crc, reflected form, one byte lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
    logic [31:0] r;
    r = c ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      r = r[0] ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] bit_rev(input logic [31:0] v);
    logic [31:0] r;
    for (int k = 0; k < 32; k++) begin
      r[k] = v[31-k];
    end
    return r;
  endfunction

  // ============================================================
  // reporting
  // ============================================================
  task automatic fail_run(input string what);
    mac_rx_pkg::parse_state_t st;
    st = i_dut.i_parser.state;
    $display("%s", what);
    $display("parser state at stop: %s", st.name());
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      fail_run("value mismatch");
    end
  endtask

  // ============================================================
  // stimulus
  // ============================================================
  task automatic make_frame(input int total_len);
    logic [31:0] c;
    frame_q.delete();
    c = '1;  // preset
    for (int k = 0; k < total_len - 4; k++) begin
      frame_q.push_back(rand_byte());
      c = crc_byte(c, frame_q[k]);
    end
    c = ~c;  // fcs goes out complemented, low byte first
    for (int k = 0; k < 4; k++) begin
      frame_q.push_back(c[8*k +: 8]);
    end
  endtask

  task automatic drive_byte(input logic [7:0] b);
    rx_dv = 1'b1;
    if (speed == mac_rx_pkg::spd_1000) begin
      rx_d = b;
      @(negedge rx_clk);
    end else begin
      rx_d = {4'h0, b[3:0]};  // low nibble first
      @(negedge rx_clk);
      rx_d = {4'h0, b[7:4]};
      @(negedge rx_clk);
    end
  endtask

  task automatic send_frame(input mac_rx_pkg::speed_t spd, input int pre_bytes, input bit with_sfd);
    speed = spd;  // parser is idle here
    for (int k = 0; k < pre_bytes; k++) begin
      drive_byte(8'h55);
    end
    if (with_sfd) begin
      drive_byte(mac_rx_pkg::sfd_byte);
      foreach (frame_q[k]) begin
        drive_byte(frame_q[k]);
      end
    end
    rx_dv = 1'b0;
    rx_d  = 8'h00;
    repeat (12) @(negedge rx_clk);  // interframe gap
  endtask

  task automatic expect_accepted();
    foreach (frame_q[k]) begin
      pend_q.push_back(frame_q[k]);
    end
    pend_len.push_back(frame_q.size());
  endtask

  // ============================================================
  // response collection
  // ============================================================
  task automatic pop_byte(input string name, output logic [7:0] b);
    int t;
    t = 0;
    data_ready = 1'b1;
    while (!data_valid) begin
      if (t == wait_limit) fail_run({name, ": data stream stalled, timeout"});
      t++;
      @(negedge rx_clk);
    end
    b = data_byte;           // taken on the next rising edge
    @(negedge rx_clk);
    data_ready = 1'b0;
  endtask

  task automatic drain_frame(input string name);
    logic [7:0]           cur_q[$];
    logic [7:0]           b;
    logic [31:0]          c;
    int                   n;
    int                   stored;
    int                   t;
    mac_rx_pkg::rx_desc_t got;
    mac_rx_pkg::rx_desc_t exp;
    if (pend_len.size() == 0) fail_run({name, ": no frame left to compare"});
    n = pend_len.pop_front();
    repeat (n) cur_q.push_back(pend_q.pop_front());
    // expected descriptor, only the first max_frame bytes get stored
    stored = (n > max_frame) ? max_frame : n;
    c = '1;
    for (int k = 0; k < stored; k++) begin
      c = crc_byte(c, cur_q[k]);
    end
    exp.byte_len = 12'(stored);
    exp.len_err  = (n > max_frame) || (stored < mac_rx_pkg::min_frame);
    exp.crc_err  = (bit_rev(c) != mac_rx_pkg::crc_residue);
    t = 0;
    desc_ready = 1'b1;
    while (!desc_valid) begin
      if (t == wait_limit) fail_run({name, ": no descriptor before timeout"});
      t++;
      @(negedge rx_clk);
    end
    got = desc;
    @(negedge rx_clk);
    desc_ready = 1'b0;
    check({name, " byte_len"}, 32'(exp.byte_len), 32'(got.byte_len));
    check({name, " crc_err"}, 32'(exp.crc_err), 32'(got.crc_err));
    check({name, " len_err"}, 32'(exp.len_err), 32'(got.len_err));
    for (int k = 0; k < stored; k++) begin
      pop_byte(name, b);
      check($sformatf("%s byte %0d", name, k), 32'(cur_q[k]), 32'(b));
    end
  endtask

  task automatic check_quiet(input string name);
    for (int k = 0; k < 20; k++) begin
      check({name, " desc_valid"}, 0, 32'(desc_valid));
      check({name, " data_valid"}, 0, 32'(data_valid));
      @(negedge rx_clk);
    end
  endtask

  task automatic run_frame(input string name, input mac_rx_pkg::speed_t spd, input int pre);
    send_frame(spd, pre, 1'b1);
    expect_accepted();
    drain_frame(name);
  endtask

  // ============================================================
  // directed tests
  // ============================================================
  task automatic test_good_1000();
    make_frame(104);  // 100 payload plus fcs
    run_frame("good_1000", mac_rx_pkg::spd_1000, 7);
  endtask

  task automatic test_nibble();
    run_frame("mii100_pre7", mac_rx_pkg::spd_100, 7);  // same frame as above
    run_frame("mii100_pre3", mac_rx_pkg::spd_100, 3);
    run_frame("mii10_pre7", mac_rx_pkg::spd_10, 7);
    run_frame("mii10_pre3", mac_rx_pkg::spd_10, 3);
    send_frame(mac_rx_pkg::spd_100, 5, 1'b0);  // preamble only
    check_quiet("no_sfd");
  endtask

  task automatic test_bad_fcs();
    frame_q[20] = frame_q[20] ^ 8'h01;
    run_frame("bad_fcs", mac_rx_pkg::spd_1000, 7);
  endtask

  task automatic test_length();
    make_frame(40);
    run_frame("runt", mac_rx_pkg::spd_1000, 7);
    make_frame(1600);
    run_frame("oversize", mac_rx_pkg::spd_1000, 7);
    check_quiet("oversize tail");  // nothing past max_frame
  endtask

  task automatic test_backpressure();
    for (int k = 0; k < 6; k++) begin
      make_frame(64);
      send_frame(mac_rx_pkg::spd_1000, 7, 1'b1);
      if (k < desc_depth) expect_accepted();  // later ones find desc fifo full
    end
    for (int k = 0; k < desc_depth; k++) begin
      drain_frame($sformatf("backpressure frame %0d", k));
    end
    check_quiet("backpressure extra");
    make_frame(64);
    run_frame("after_drain", mac_rx_pkg::spd_1000, 7);
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    rstn       = 1'b0;
    rx_dv      = 1'b0;
    rx_d       = 8'h00;
    speed      = mac_rx_pkg::spd_1000;
    data_ready = 1'b0;
    desc_ready = 1'b0;
    lcg_state  = 32'h395b1da1;
    repeat (4) @(posedge rx_clk);  // four rising edges in reset
    @(negedge rx_clk);
    rstn = 1'b1;
    @(negedge rx_clk);
    check("reset data_valid", 0, 32'(data_valid));
    check("reset desc_valid", 0, 32'(desc_valid));
    test_good_1000();
    test_nibble();
    test_bad_fcs();
    test_length();
    test_backpressure();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
src/mac_rx_pkg.sv
src/mac_rx_crc32.sv
src/mac_rx_sync_fifo.sv
src/mac_rx_frame_parser.sv
src/mac_rx_top.sv
testbench/tb_mac_rx.sv

/* Makefile */
TOP := tb_mac_rx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
